// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_saturn_pad
FLIST      := flist.f
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== flist.f ====
saturn_pad_pkg.sv
pad_step_if.sv
pad_step_sequencer.sv
pad_nibble_encoder.sv
port_pin_mux.sv
saturn_pad_top.sv
tb_saturn_pad.sv

// ==== pad_nibble_encoder.sv ====
`timescale 1ns/1ns

module pad_nibble_encoder (
	input  logic                      CLK,
	input  logic                      RST_N,
	input  saturn_pad_pkg::pad_type_t pad_type,
	input  saturn_pad_pkg::buttons_t  buttons,
	input  saturn_pad_pkg::axis_t     axis_x,
	input  saturn_pad_pkg::axis_t     axis_y,
	pad_step_if.enc                   step,
	output saturn_pad_pkg::nibble_t   nibble,
	output logic                      tl
);
	import saturn_pad_pkg::*;

	nibble_t id_nibble;

	assign id_nibble = (pad_type == PAD_3D) ? ID_3D : ID_MISSION;

	// Acknowledge comes straight from the sequencer
	assign tl = step.tl;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			nibble <= '0;
		end else if (step.home) begin
			nibble <= 4'h1;
		end else if (step.load) begin
			case (step.next_step)
				// Header nibbles
				5'd2,
				5'd3:  nibble <= 4'h1;
				5'd4:  nibble <= id_nibble;
				// Buttons, high nibble first
				5'd5:  nibble <= buttons[15:12];
				5'd6:  nibble <= buttons[11:8];
				5'd7:  nibble <= buttons[7:4];
				5'd8:  nibble <= buttons[3:0];
				// Axes go out offset binary
				5'd9:  nibble <= {~axis_x[7], axis_x[6:4]};
				5'd10: nibble <= axis_x[3:0];
				5'd11: nibble <= {~axis_y[7], axis_y[6:4]};
				5'd12: nibble <= axis_y[3:0];
				// End marker of the 3D pad
				5'd16: nibble <= 4'h1;
				// Triggers are not modeled, steps 13 to 15 send zero
				default: nibble <= 4'h0;
			endcase
		end
	end

	// Output only moves on a sequencer event
	a_nibble_on_event: assert property (
		@(posedge CLK) disable iff (!RST_N)
		$changed(nibble) |-> $past(step.load || step.home)
	);

endmodule

// ==== pad_step_if.sv ====
`timescale 1ns/1ns

interface pad_step_if;
	import saturn_pad_pkg::*;

	// Advance pulse, one cycle, already qualified by the clock enable
	logic  load;
	// Step that load enters
	step_t next_step;
	// Restart pulse for TH/TR both high
	logic  home;
	// Acknowledge level held by the sequencer
	logic  tl;

	// Sequencer side
	modport seq (
		output load,
		output next_step,
		output home,
		output tl
	);

	// Encoder side
	modport enc (
		input load,
		input next_step,
		input home,
		input tl
	);

endinterface

// ==== pad_step_sequencer.sv ====
`timescale 1ns/1ns

module pad_step_sequencer (
	input  logic                      CLK,
	input  logic                      RST_N,
	input  logic                      smpc_ce,
	input  logic [1:0]                th_tr,
	input  saturn_pad_pkg::pad_type_t pad_type,
	pad_step_if.seq                   step
);
	import saturn_pad_pkg::*;

	step_t step_q;
	logic  tl_q;
	step_t next_step;
	step_t last_step;
	logic  active;
	logic  advance;

	// Only the serial pads run the sequence
	assign active = smpc_ce && (pad_type == PAD_MISSION || pad_type == PAD_3D);

	// Mission stick ends two steps early
	assign last_step = (pad_type == PAD_3D) ? LAST_STEP_3D : LAST_STEP_MISSION;

	// Steps 0 and 1 both jump straight to the first data step
	assign next_step = (step_q < FIRST_STEP) ? FIRST_STEP : step_q + 5'd1;

	always_comb begin
		advance = 1'b0;
		if (step_q < FIRST_STEP) begin
			// TH low, TR high starts the exchange
			advance = (th_tr == 2'b01);
		end else if (step_q < last_step) begin
			// Odd step waits for TR high, even step for TR low
			if (step_q[0])
				advance = (th_tr == 2'b01);
			else
				advance = (th_tr == 2'b00);
		end
	end

	assign step.load      = active && advance;
	assign step.home      = active && (th_tr == 2'b11);
	assign step.next_step = next_step;
	assign step.tl        = tl_q;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			step_q <= '0;
			tl_q   <= 1'b1;
		end else if (step.home) begin
			step_q <= '0;
			tl_q   <= 1'b1;
		end else if (step.load) begin
			step_q <= next_step;
			// TL tracks step parity, high on even
			tl_q   <= ~next_step[0];
		end
	end

	// Home pattern never matches an advance pattern
	a_load_home_excl: assert property (
		@(posedge CLK) disable iff (!RST_N)
		!(step.load && step.home)
	);

	// Sequence stays inside the longest pad's range
	a_step_range: assert property (
		@(posedge CLK) disable iff (!RST_N)
		step_q <= LAST_STEP_3D
	);

endmodule

// ==== port_pin_mux.sv ====
`timescale 1ns/1ns

module port_pin_mux (
	input  saturn_pad_pkg::pad_type_t  pad_type,
	input  saturn_pad_pkg::port_bits_t pdr_out,
	input  saturn_pad_pkg::port_bits_t ddr,
	input  saturn_pad_pkg::buttons_t   buttons,
	input  saturn_pad_pkg::nibble_t    nibble,
	input  logic                       tl,
	output saturn_pad_pkg::port_bits_t pdr_in
);
	import saturn_pad_pkg::*;

	nibble_t b3_nibble;

	// Digital pad ID pattern with the L button on top
	assign b3_nibble = {buttons[3], 3'b100};

	always_comb begin
		// Host outputs read back, inputs pulled high
		pdr_in = (pdr_out & ddr) | ~ddr;
		case (pad_type)
			PAD_DIGITAL: begin
				if (ddr[TH_BIT:TR_BIT] == 2'b10) begin
					// TH only select
					if (pdr_out[TH_BIT])
						pdr_in[3:0] = b3_nibble;
					else
						pdr_in[3:0] = buttons[15:12];
				end else if (ddr[TH_BIT:TR_BIT] == 2'b11) begin
					// TH/TR select
					case (pdr_out[TH_BIT:TR_BIT])
						2'b00: pdr_in[3:0] = buttons[7:4];
						2'b01: pdr_in[3:0] = buttons[15:12];
						2'b10: pdr_in[3:0] = buttons[11:8];
						2'b11: pdr_in[3:0] = b3_nibble;
					endcase
				end
			end

			PAD_MISSION,
			PAD_3D: begin
				// Serial data with acknowledge on bit 4
				pdr_in[4:0] = {tl, nibble};
			end

			// Nothing plugged in
			PAD_OFF: ;

			default: ;
		endcase
	end

endmodule

// ==== saturn_pad_pkg.sv ====
package saturn_pad_pkg;

	// Port data or direction register, bits 6:0
	typedef logic [6:0] port_bits_t;

	// One nibble on the port's low four bits
	typedef logic [3:0] nibble_t;

	// Active-low button word from the host side
	typedef logic [15:0] buttons_t;

	// Signed analog axis, zero at center
	typedef logic signed [7:0] axis_t;

	// Pad type selector
	typedef logic [2:0] pad_type_t;

	// Position in the nibble-serial protocol
	typedef logic [4:0] step_t;

	// Pad type codes, gaps belong to the dropped pad kinds
	localparam pad_type_t PAD_DIGITAL = 3'd0;
	localparam pad_type_t PAD_OFF     = 3'd1;
	localparam pad_type_t PAD_MISSION = 3'd3;
	localparam pad_type_t PAD_3D      = 3'd4;

	// TH and TR line positions in the port registers
	localparam int TH_BIT = 6;
	localparam int TR_BIT = 5;

	// Identification nibbles sent at step 4
	localparam nibble_t ID_MISSION = 4'h5;
	localparam nibble_t ID_3D      = 4'h6;

	// First step entered after home
	localparam step_t FIRST_STEP = 5'd2;

	// Final steps per pad type
	// Mission stick stops after the Z1 pair
	localparam step_t LAST_STEP_MISSION = 5'd14;
	// 3D pad carries two more nibbles
	localparam step_t LAST_STEP_3D      = 5'd16;

endpackage

// ==== saturn_pad_top.sv ====
`timescale 1ns/1ns

module saturn_pad_top (
	input  logic                       CLK,
	input  logic                       RST_N,
	input  logic                       smpc_ce,

	// Port 1
	input  saturn_pad_pkg::port_bits_t pdr1_out,
	input  saturn_pad_pkg::port_bits_t ddr1,
	output saturn_pad_pkg::port_bits_t pdr1_in,
	input  saturn_pad_pkg::buttons_t   joy1,
	input  saturn_pad_pkg::axis_t      joy1_x,
	input  saturn_pad_pkg::axis_t      joy1_y,
	input  saturn_pad_pkg::pad_type_t  joy1_type,

	// Port 2
	input  saturn_pad_pkg::port_bits_t pdr2_out,
	input  saturn_pad_pkg::port_bits_t ddr2,
	output saturn_pad_pkg::port_bits_t pdr2_in,
	input  saturn_pad_pkg::buttons_t   joy2,
	input  saturn_pad_pkg::axis_t      joy2_x,
	input  saturn_pad_pkg::axis_t      joy2_y,
	input  saturn_pad_pkg::pad_type_t  joy2_type
);
	import saturn_pad_pkg::*;

	nibble_t nibble1;
	nibble_t nibble2;
	logic    tl1;
	logic    tl2;

	pad_step_if step1_if ();
	pad_step_if step2_if ();

	// Port 1 channel
	pad_step_sequencer u_seq1 (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.smpc_ce  (smpc_ce),
		.th_tr    (pdr1_out[TH_BIT:TR_BIT]),
		.pad_type (joy1_type),
		.step     (step1_if.seq)
	);

	pad_nibble_encoder u_enc1 (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.pad_type (joy1_type),
		.buttons  (joy1),
		.axis_x   (joy1_x),
		.axis_y   (joy1_y),
		.step     (step1_if.enc),
		.nibble   (nibble1),
		.tl       (tl1)
	);

	port_pin_mux u_mux1 (
		.pad_type (joy1_type),
		.pdr_out  (pdr1_out),
		.ddr      (ddr1),
		.buttons  (joy1),
		.nibble   (nibble1),
		.tl       (tl1),
		.pdr_in   (pdr1_in)
	);

	// Port 2 channel
	pad_step_sequencer u_seq2 (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.smpc_ce  (smpc_ce),
		.th_tr    (pdr2_out[TH_BIT:TR_BIT]),
		.pad_type (joy2_type),
		.step     (step2_if.seq)
	);

	pad_nibble_encoder u_enc2 (
		.CLK      (CLK),
		.RST_N    (RST_N),
		.pad_type (joy2_type),
		.buttons  (joy2),
		.axis_x   (joy2_x),
		.axis_y   (joy2_y),
		.step     (step2_if.enc),
		.nibble   (nibble2),
		.tl       (tl2)
	);

	port_pin_mux u_mux2 (
		.pad_type (joy2_type),
		.pdr_out  (pdr2_out),
		.ddr      (ddr2),
		.buttons  (joy2),
		.nibble   (nibble2),
		.tl       (tl2),
		.pdr_in   (pdr2_in)
	);

endmodule

// ==== tb_saturn_pad.sv ====
`timescale 1ns/1ns

module tb_saturn_pad;
	import saturn_pad_pkg::*;

	// About 450 stimulus cycles in total, generous margin on top
	localparam int CYCLE_LIMIT = 2000;

	logic       CLK;
	logic       RST_N;
	logic       smpc_ce;
	port_bits_t pdr_out[1:2];
	port_bits_t ddr[1:2];
	port_bits_t pdr_in[1:2];
	buttons_t   joy[1:2];
	axis_t      joy_x[1:2];
	axis_t      joy_y[1:2];
	pad_type_t  joy_type[1:2];

	// Reference state of each port's serial protocol
	step_t      m_step[1:2];
	logic       m_tl[1:2];
	nibble_t    m_nib[1:2];
	port_bits_t exp_in[1:2];

	logic [31:0] rng;
	string       test_name;
	int          cycles;

	saturn_pad_top u_dut (
		.CLK       (CLK),
		.RST_N     (RST_N),
		.smpc_ce   (smpc_ce),
		.pdr1_out  (pdr_out[1]),
		.ddr1      (ddr[1]),
		.pdr1_in   (pdr_in[1]),
		.joy1      (joy[1]),
		.joy1_x    (joy_x[1]),
		.joy1_y    (joy_y[1]),
		.joy1_type (joy_type[1]),
		.pdr2_out  (pdr_out[2]),
		.ddr2      (ddr[2]),
		.pdr2_in   (pdr_in[2]),
		.joy2      (joy[2]),
		.joy2_x    (joy_x[2]),
		.joy2_y    (joy_y[2]),
		.joy2_type (joy_type[2])
	);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Nibble a serial pad sends in a given step
	function automatic nibble_t step_nibble(input step_t s, input pad_type_t ty,
			input buttons_t b, input axis_t x, input axis_t y);
		nibble_t n;
		case (s)
			5'd2, 5'd3: n = 4'h1;
			// 3D pad identifies as 6, mission stick as 5
			5'd4:       n = (ty == PAD_3D) ? 4'h6 : 4'h5;
			5'd5:       n = b[15:12];
			5'd6:       n = b[11:8];
			5'd7:       n = b[7:4];
			5'd8:       n = b[3:0];
			5'd9:       n = {~x[7], x[6:4]};
			5'd10:      n = x[3:0];
			5'd11:      n = {~y[7], y[6:4]};
			5'd12:      n = y[3:0];
			5'd16:      n = 4'h1;
			default:    n = 4'h0;
		endcase
		return n;
	endfunction

	// Expected port input value
	function automatic port_bits_t expected_port(input pad_type_t ty, input port_bits_t out,
			input port_bits_t dir, input buttons_t b, input logic tl, input nibble_t nib);
		port_bits_t v;
		v = (out & dir) | ~dir;
		if (ty == PAD_DIGITAL && dir[TH_BIT:TR_BIT] == 2'b11) begin
			case (out[TH_BIT:TR_BIT])
				2'b00: v[3:0] = b[7:4];
				2'b01: v[3:0] = b[15:12];
				2'b10: v[3:0] = b[11:8];
				2'b11: v[3:0] = {b[3], 3'b100};
			endcase
		end else if (ty == PAD_DIGITAL && dir[TH_BIT:TR_BIT] == 2'b10) begin
			v[3:0] = out[TH_BIT] ? {b[3], 3'b100} : b[15:12];
		end else if (ty == PAD_MISSION || ty == PAD_3D) begin
			v[4:0] = {tl, nib};
		end
		return v;
	endfunction

	assign exp_in[1] = expected_port(joy_type[1], pdr_out[1], ddr[1], joy[1], m_tl[1], m_nib[1]);
	assign exp_in[2] = expected_port(joy_type[2], pdr_out[2], ddr[2], joy[2], m_tl[2], m_nib[2]);

	// Applies the rising edge that closed the cycle, using the inputs held during it
	task automatic advance_model(input int p);
		step_t      last;
		logic [1:0] pat;
		logic       enter;
		pat   = pdr_out[p][TH_BIT:TR_BIT];
		// Mission stick stops at 14, 3D pad at 16
		last  = (joy_type[p] == PAD_3D) ? 5'd16 : 5'd14;
		enter = 1'b0;
		if (!RST_N) begin
			m_step[p] = '0;
			m_tl[p]   = 1'b1;
			m_nib[p]  = '0;
		end else if (smpc_ce && (joy_type[p] == PAD_MISSION || joy_type[p] == PAD_3D)) begin
			if (pat == 2'b11) begin
				m_step[p] = '0;
				m_tl[p]   = 1'b1;
				m_nib[p]  = 4'h1;
			end else if (m_step[p] < 5'd2) begin
				enter = (pat == 2'b01);
			end else if (m_step[p] < last) begin
				enter = m_step[p][0] ? (pat == 2'b01) : (pat == 2'b00);
			end
			if (enter) begin
				m_step[p] = (m_step[p] < 5'd2) ? 5'd2 : m_step[p] + 5'd1;
				m_tl[p]   = ~m_step[p][0];
				m_nib[p]  = step_nibble(m_step[p], joy_type[p], joy[p], joy_x[p], joy_y[p]);
			end
		end
	endtask

	// Falling edge, inputs may change right after
	task automatic next_cycle();
		@(negedge CLK);
		advance_model(1);
		advance_model(2);
	endtask

	task automatic randomize_inputs(input int p);
		rng        = xorshift(rng);
		joy[p]     = rng[15:0];
		joy_x[p]   = rng[23:16];
		joy_y[p]   = rng[31:24];
		rng        = xorshift(rng);
		pdr_out[p] = rng[6:0];
		ddr[p]     = rng[14:8];
	endtask

	// TH/TR as outputs on both ports, same pattern on each
	task automatic serial_cycle(input logic [1:0] pat, input logic ce);
		next_cycle();
		smpc_ce = ce;
		for (int p = 1; p <= 2; p++) begin
			randomize_inputs(p);
			ddr[p][TH_BIT:TR_BIT]     = 2'b11;
			pdr_out[p][TH_BIT:TR_BIT] = pat;
		end
	endtask

	task automatic apply_reset();
		next_cycle();
		RST_N = 1'b0;
		repeat (4) next_cycle();
		RST_N = 1'b1;
	endtask

	task automatic report_mismatch(input int p, input port_bits_t e, input port_bits_t a);
		$display("Mismatch in %s on port %0d: expected %b, actual %b", test_name, p, e, a);
		$display("Some tests failed");
		$fatal(1, "Port value check failed");
	endtask

	a_port1_value: assert property (@(posedge CLK) disable iff (!RST_N) pdr_in[1] == exp_in[1])
		else report_mismatch(1, $sampled(exp_in[1]), $sampled(pdr_in[1]));

	a_port2_value: assert property (@(posedge CLK) disable iff (!RST_N) pdr_in[2] == exp_in[2])
		else report_mismatch(2, $sampled(exp_in[2]), $sampled(pdr_in[2]));

	initial begin
		CLK = 1'b0;
		forever #50 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		cycles++;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("Some tests failed");
			$fatal(1, "Timeout");
		end
	end

	initial begin
		cycles    = 0;
		rng       = 32'h9b60;
		test_name = "reset";
		RST_N     = 1'b0;
		smpc_ce   = 1'b1;
		for (int p = 1; p <= 2; p++) begin
			pdr_out[p]  = '0;
			ddr[p]      = '0;
			joy[p]      = '1;
			joy_x[p]    = '0;
			joy_y[p]    = '0;
			joy_type[p] = PAD_OFF;
			m_step[p]   = '0;
			m_tl[p]     = 1'b1;
			m_nib[p]    = '0;
		end
		repeat (4) next_cycle();
		RST_N = 1'b1;

		// Nothing plugged in, pure readback
		test_name = "pass_through";
		repeat (200) begin
			next_cycle();
			randomize_inputs(1);
			randomize_inputs(2);
		end

		test_name   = "direct_th_tr";
		joy_type[1] = PAD_DIGITAL;
		joy_type[2] = PAD_DIGITAL;
		for (int i = 0; i < 100; i++) begin
			next_cycle();
			for (int p = 1; p <= 2; p++) begin
				randomize_inputs(p);
				ddr[p][TH_BIT:TR_BIT]     = 2'b11;
				pdr_out[p][TH_BIT:TR_BIT] = (p == 1) ? i[1:0] : ~i[1:0];
			end
		end

		test_name = "direct_th_only";
		for (int i = 0; i < 100; i++) begin
			next_cycle();
			for (int p = 1; p <= 2; p++) begin
				randomize_inputs(p);
				ddr[p][TH_BIT:TR_BIT] = 2'b10;
				pdr_out[p][TH_BIT]    = i[0];
			end
		end

		// Port 1 mission stick, port 2 3D pad
		test_name   = "serial_after_reset";
		joy_type[1] = PAD_MISSION;
		joy_type[2] = PAD_3D;
		for (int p = 1; p <= 2; p++) begin
			ddr[p][TH_BIT:TR_BIT]     = 2'b11;
			pdr_out[p][TH_BIT:TR_BIT] = 2'b10;
		end
		apply_reset();
		repeat (3) serial_cycle(2'b10, 1'b1);

		// Twenty toggles run both pads past their last step
		test_name = "serial_sequence";
		for (int i = 0; i < 20; i++)
			serial_cycle(i[0] ? 2'b00 : 2'b01, 1'b1);

		test_name = "serial_home";
		serial_cycle(2'b11, 1'b1);
		for (int i = 0; i < 6; i++)
			serial_cycle(i[0] ? 2'b00 : 2'b01, 1'b1);
		// Second home lands mid-sequence, at step 7 on both pads
		serial_cycle(2'b11, 1'b1);
		for (int i = 0; i < 6; i++)
			serial_cycle(i[0] ? 2'b00 : 2'b01, 1'b1);

		test_name = "serial_ce_low";
		for (int i = 0; i < 6; i++)
			serial_cycle(i[0] ? 2'b00 : 2'b01, 1'b0);

		next_cycle();
		$display("All tests passed");
		$finish;
	end

endmodule
